//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_uart_hub
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- common/axis_if.sv
// Valid/ready stream interface with the payload given as a type parameter
interface axis_if #(
    parameter type payload_t = logic [7:0]
) ();

    logic     tvalid;   // Source offers a beat
    logic     tready;   // Sink takes it on this edge
    payload_t tdata;

    modport master (output tvalid, output tdata, input tready);
    modport slave  (input tvalid, input tdata, output tready);

endinterface

//--- common/stream_pkg.sv
// Stream package with the channel id and the tagged beat of the hub output
package stream_pkg;

    import uart_pkg::*;

    // Channel a beat came from
    typedef logic ch_id_t;

    // Output beat of the hub, channel id on top of the data byte
    typedef struct packed {
        ch_id_t     ch;
        uart_byte_t data;
    } hub_beat_t;

endpackage

//--- common/uart_pkg.sv
// UART package with the received byte type and the receiver FSM states
package uart_pkg;

    // Data bits in one frame, no parity
    localparam int UART_DATA_BITS = 8;

    // One received data byte
    typedef logic [UART_DATA_BITS-1:0] uart_byte_t;

    // Receiver FSM
    typedef enum logic [2:0] {
        RX_IDLE  = 3'b000,   // Line idle, waiting for a falling edge
        RX_START = 3'b001,   // Half a bit to the middle of the start bit
        RX_DATA  = 3'b010,   // Eight data bits, LSB first
        RX_STOP  = 3'b011,   // Stop bit period, level not checked
        RX_WAIT  = 3'b100    // One cycle before going idle again
    } rx_state_t;

endpackage

//--- src.f
common/uart_pkg.sv
common/stream_pkg.sv
common/axis_if.sv
uart_rx/axis_uart_rx.sv
src/stream_fifo.sv
src/rr_stream_arbiter.sv
src/uart_hub_top.sv
tests/tb_uart_hub.sv

//--- src/rr_stream_arbiter.sv
// Round-robin arbiter that merges byte streams into one registered, channel-tagged stream
module rr_stream_arbiter
    import uart_pkg::*, stream_pkg::*;
#(
    parameter int N_PORTS = 2
) (
    input  logic      clk_i,
    input  logic      arstn_i,
    axis_if.slave     s_axis [N_PORTS],
    output logic      out_valid_o,
    output hub_beat_t out_data_o,
    input  logic      out_ready_i
);

    localparam int IDX_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

    logic [N_PORTS-1:0] req;
    uart_byte_t         req_data [N_PORTS];
    logic [IDX_W-1:0]   last_q;
    logic [IDX_W-1:0]   pick;
    logic               found;
    logic               load;
    logic               grant;
    logic               out_valid_q;
    hub_beat_t          out_data_q;

    for (genvar i = 0; i < N_PORTS; i++) begin : g_port
        assign req[i]           = s_axis[i].tvalid;
        assign req_data[i]      = s_axis[i].tdata;
        assign s_axis[i].tready = grant && (pick == IDX_W'(i));   // Only the winner
    end

    ////////////////////////////////////////////////////////////
    // Round-robin choice
    ////////////////////////////////////////////////////////////

    // Search starts at the port after the previous winner
    always_comb begin
        int cand;
        found = 1'b0;
        pick  = last_q;
        for (int k = 1; k <= N_PORTS; k++) begin
            cand = (int'(last_q) + k) % N_PORTS;
            if (!found && req[cand]) begin
                found = 1'b1;
                pick  = IDX_W'(cand);
            end
        end
    end

    // Output register is free or leaving on this edge
    assign load  = !out_valid_q || out_ready_i;
    assign grant = load && found;

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            out_valid_q <= 1'b0;
            last_q      <= IDX_W'(N_PORTS - 1);   // So port 0 goes first
        end else if (load) begin
            out_valid_q <= found;
            if (found) begin
                last_q <= pick;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (grant) begin
            out_data_q.ch   <= ch_id_t'(pick);
            out_data_q.data <= req_data[pick];
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_data_o  = out_data_q;

endmodule

//--- src/stream_fifo.sv
// Stream FIFO, a small circular buffer between a slave and a master stream
module stream_fifo #(
    parameter type payload_t  = logic [7:0],
    parameter int  FIFO_DEPTH = 4
) (
    input  logic   clk_i,
    input  logic   arstn_i,
    axis_if.slave  s_axis,
    axis_if.master m_axis
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(FIFO_DEPTH);

    payload_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign wr_en = s_axis.tvalid && s_axis.tready;
    assign rd_en = m_axis.tvalid && m_axis.tready;

    assign s_axis.tready = (count != FULL);
    assign m_axis.tvalid = (count != '0);
    assign m_axis.tdata  = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr] <= s_axis.tdata;
        end
    end

    // Depth is a power of two, so the pointers wrap by themselves
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Idle, or read and write together
            endcase
        end
    end

endmodule

//--- src/uart_hub_top.sv
// Two-channel UART receive hub with a receiver and a FIFO per line and one merged output
module uart_hub_top
    import uart_pkg::*, stream_pkg::*;
#(
    parameter int CLK_FREQ   = 25_000_000,
    parameter int BAUD_RATE  = 1_562_500,
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk_i,
    input  logic      arstn_i,
    input  logic      uart_rx0_i,
    input  logic      uart_rx1_i,
    output logic      out_valid_o,
    output hub_beat_t out_data_o,
    input  logic      out_ready_i
);

    localparam int N_PORTS = 2;

    // Receiver to FIFO, then FIFO to arbiter
    axis_if #(.payload_t(uart_byte_t)) rx_stream   [N_PORTS] ();
    axis_if #(.payload_t(uart_byte_t)) fifo_stream [N_PORTS] ();

    axis_uart_rx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) u_rx0 (
        .clk_i     (clk_i),
        .arstn_i   (arstn_i),
        .uart_rx_i (uart_rx0_i),
        .m_axis    (rx_stream[0])
    );

    axis_uart_rx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) u_rx1 (
        .clk_i     (clk_i),
        .arstn_i   (arstn_i),
        .uart_rx_i (uart_rx1_i),
        .m_axis    (rx_stream[1])
    );

    stream_fifo #(
        .payload_t  (uart_byte_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo0 (
        .clk_i   (clk_i),
        .arstn_i (arstn_i),
        .s_axis  (rx_stream[0]),
        .m_axis  (fifo_stream[0])
    );

    stream_fifo #(
        .payload_t  (uart_byte_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo1 (
        .clk_i   (clk_i),
        .arstn_i (arstn_i),
        .s_axis  (rx_stream[1]),
        .m_axis  (fifo_stream[1])
    );

    rr_stream_arbiter #(
        .N_PORTS (N_PORTS)
    ) u_arb (
        .clk_i       (clk_i),
        .arstn_i     (arstn_i),
        .s_axis      (fifo_stream),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_ready_i (out_ready_i)
    );

endmodule

//--- tests/tb_uart_hub.sv
// Testbench for the UART hub that plays frames and expected beats from a stimulus file
module tb_uart_hub
    import uart_pkg::*, stream_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_FREQ    = 25_000_000;
    localparam int BAUD_RATE   = 1_562_500;
    localparam int FIFO_DEPTH  = 4;
    localparam int BIT_CLKS    = CLK_FREQ / BAUD_RATE;
    localparam int BEAT_LIMIT  = 20 * BIT_CLKS;   // Two frame times
    localparam int DRAIN_LIMIT = 2000;

    logic       clk_i;
    logic       arstn_i;
    logic [1:0] rx_line;
    logic       out_ready;
    logic       out_valid;
    hub_beat_t  out_data;
    hub_beat_t  beat_q [$];
    int         cur_test;
    int         test_errs;
    int         n_pass;
    int         n_fail;

    uart_hub_top #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .clk_i       (clk_i),
        .arstn_i     (arstn_i),
        .uart_rx0_i  (rx_line[0]),
        .uart_rx1_i  (rx_line[1]),
        .out_valid_o (out_valid),
        .out_data_o  (out_data),
        .out_ready_i (out_ready)
    );

    always #20 clk_i = ~clk_i;

    // A beat seen here transfers on the next rising edge
    always @(negedge clk_i) begin
        if (arstn_i && out_valid && out_ready) begin
            beat_q.push_back(out_data);
        end
    end

    ////////////////////////////////////////////////////////////
    // Driving and checking
    ////////////////////////////////////////////////////////////

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error at %0.1f ns: %s expected 0x%0h, actual 0x%0h",
                     $realtime, name, expected, actual);
            test_errs++;
        end
    endtask

    // Start bit, eight data bits LSB first, one stop bit
    task automatic send_frame(input ch_id_t ch, input uart_byte_t value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx_line[ch] = frame[i];
            wait_cycles(BIT_CLKS);
        end
    endtask

    task automatic send_glitch(input ch_id_t ch);
        rx_line[ch] = 1'b0;
        wait_cycles(BIT_CLKS / 4);   // A quarter bit only
        rx_line[ch] = 1'b1;
        wait_cycles(1);
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            wait_cycles(1);
            check_value("out_valid_o", 32'(1'b0), 32'(out_valid));
        end
    endtask

    // Takes the oldest beat of the channel, so per-channel order is checked
    task automatic expect_beat(input ch_id_t ch, input uart_byte_t value);
        int idx;
        int cycles;
        idx    = -1;
        cycles = 0;
        while (idx < 0 && cycles < BEAT_LIMIT) begin
            foreach (beat_q[i]) begin
                if (idx < 0 && beat_q[i].ch == ch) begin
                    idx = i;
                end
            end
            if (idx < 0) begin
                wait_cycles(1);
                cycles++;
            end
        end
        if (idx < 0) begin
            $display("Test %0d: no beat from channel %0d arrived within %0d cycles",
                     cur_test, ch, BEAT_LIMIT);
            test_errs++;
        end else begin
            check_value("out_data_o.data", 32'(value), 32'(beat_q[idx].data));
            beat_q.delete(idx);
        end
    endtask

    task automatic drain_with_gaps(input int n);
        int   cycles;
        logic seen0;
        logic seen1;
        cycles = 0;
        while (beat_q.size() < n && cycles < DRAIN_LIMIT) begin
            out_ready = ($urandom_range(0, 2) != 0);
            wait_cycles(1);
            cycles++;
        end
        out_ready = 1'b1;
        if (beat_q.size() < n) begin
            $display("Test %0d: only %0d of %0d beats arrived before the timeout",
                     cur_test, beat_q.size(), n);
            test_errs++;
        end
        // While both channels still wait, the channel must change from beat to beat
        for (int i = 0; i + 1 < beat_q.size(); i++) begin
            seen0 = 1'b0;
            seen1 = 1'b0;
            for (int j = i; j < beat_q.size(); j++) begin
                if (beat_q[j].ch) begin
                    seen1 = 1'b1;
                end else begin
                    seen0 = 1'b1;
                end
            end
            if (seen0 && seen1) begin
                check_value("out_data_o.ch", 32'(!beat_q[i].ch), 32'(beat_q[i+1].ch));
            end
        end
    endtask

    task automatic finish_test();
        check_value("beats left on out_data_o", 0, beat_q.size());
        beat_q.delete();
        if (test_errs == 0) begin
            n_pass++;
            $display("Test %0d passed", cur_test);
        end else begin
            n_fail++;
            $display("Test %0d failed with %0d errors", cur_test, test_errs);
        end
    endtask

    task automatic run_step(input logic [63:0] cmd, input logic [15:0] arg_a,
                            input logic [15:0] arg_b);
        case (cmd)
            64'("send"):    send_frame(arg_a[0], arg_b[7:0]);
            64'("pair"): begin
                fork
                    send_frame(1'b0, arg_a[7:0]);
                    send_frame(1'b1, arg_b[7:0]);
                join
            end
            64'("glitch"):  send_glitch(arg_a[0]);
            64'("quiet"):   expect_quiet(int'(arg_b));
            64'("stall"):   out_ready = 1'b0;
            64'("release"): drain_with_gaps(int'(arg_b));
            64'("expect"):  expect_beat(arg_a[0], arg_b[7:0]);
            default: begin
                $display("Test %0d: the stimulus file holds an unknown command", cur_test);
                test_errs++;
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int          fd;
        string       line;
        int          num;
        logic [63:0] cmd;
        logic [15:0] arg_a;
        logic [15:0] arg_b;
        clk_i     = 1'b0;
        arstn_i   = 1'b0;
        rx_line   = 2'b11;   // Idle lines are high
        out_ready = 1'b1;
        cur_test  = 0;
        test_errs = 0;
        n_pass    = 0;
        n_fail    = 0;
        void'($urandom(32'h062c70c3));
        wait_cycles(16);
        arstn_i = 1'b1;

        fd = $fopen("tests/uart_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tests/uart_stimulus.txt");
            n_fail++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#" &&
                    $sscanf(line, "%d %s %h %h", num, cmd, arg_a, arg_b) == 4) begin
                    if (num != cur_test) begin
                        if (cur_test != 0) begin
                            finish_test();
                        end
                        cur_test  = num;
                        test_errs = 0;
                    end
                    run_step(cmd, arg_a, arg_b);
                end
            end
            $fclose(fd);
            if (cur_test != 0) begin
                finish_test();
            end
        end

        $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && n_pass > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- tests/uart_stimulus.txt
# test command a b, with a and b in hex. send/expect: a channel, b byte. pair: a on ch0, b on ch1
# glitch: a channel. quiet: b cycles without a beat. stall, then release: b beats to collect
1 quiet   0 28
2 send    0 a5
2 expect  0 a5
2 send    1 3c
2 expect  1 3c
3 glitch  0 0
3 quiet   0 140
3 glitch  1 0
3 quiet   0 140
4 pair    5a c3
4 pair    01 80
4 expect  0 5a
4 expect  0 01
4 expect  1 c3
4 expect  1 80
5 stall   0 0
5 pair    11 21
5 pair    12 22
5 pair    13 23
5 release 0 6
5 expect  0 11
5 expect  0 12
5 expect  0 13
5 expect  1 21
5 expect  1 22
5 expect  1 23

//--- uart_rx/axis_uart_rx.sv
// UART receiver that turns one serial frame into one beat on a valid/ready stream
module axis_uart_rx
    import uart_pkg::*;
#(
    parameter int CLK_FREQ  = 25_000_000,
    parameter int BAUD_RATE = 1_562_500
) (
    input  logic   clk_i,
    input  logic   arstn_i,
    input  logic   uart_rx_i,
    axis_if.master m_axis
);

    localparam int RATIO = CLK_FREQ / BAUD_RATE;   // Clocks per bit
    localparam int CNT_W = $clog2(RATIO);
    localparam int BIT_W = $clog2(UART_DATA_BITS);
    localparam logic [CNT_W-1:0] FULL_TICK = CNT_W'(RATIO - 1);
    localparam logic [CNT_W-1:0] HALF_TICK = CNT_W'(RATIO / 2 - 1);
    localparam logic [BIT_W-1:0] LAST_BIT  = BIT_W'(UART_DATA_BITS - 1);

    rx_state_t        state;
    logic [1:0]       rx_sync;
    logic             rx_line;
    logic [CNT_W-1:0] baud_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic             baud_tick;
    logic             data_done;
    logic             data_done_d;
    uart_byte_t       rx_shift;
    uart_byte_t       tdata_q;
    logic             tvalid_q;

    ////////////////////////////////////////////////////////////
    // Line synchronizer and bit timing
    ////////////////////////////////////////////////////////////

    // The serial line is asynchronous to clk_i
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            rx_sync <= 2'b11;   // Idle line is high
        end else begin
            rx_sync <= {rx_sync[0], uart_rx_i};
        end
    end

    assign rx_line = rx_sync[1];

    // The start state ends in the middle of the start bit, so every later tick
    // lands in the middle of a bit
    assign baud_tick = (state == RX_START) ? (baud_cnt == HALF_TICK) : (baud_cnt == FULL_TICK);
    assign data_done = (state == RX_DATA) && baud_tick && (bit_cnt == LAST_BIT);

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            baud_cnt <= '0;
        end else if ((state inside {RX_START, RX_DATA, RX_STOP}) && !baud_tick) begin
            baud_cnt <= baud_cnt + 1'b1;
        end else begin
            baud_cnt <= '0;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            bit_cnt <= '0;
        end else if (state != RX_DATA) begin
            bit_cnt <= '0;
        end else if (baud_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state <= RX_IDLE;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (!rx_line) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // A high line at mid start bit was only a glitch
                    if (baud_tick) begin
                        state <= rx_line ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (data_done) begin
                        state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (baud_tick) begin
                        state <= RX_WAIT;
                    end
                end
                RX_WAIT: state <= RX_IDLE;
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first and shifts down from the top
    always_ff @(posedge clk_i) begin
        if ((state == RX_DATA) && baud_tick) begin
            rx_shift <= {rx_line, rx_shift[UART_DATA_BITS-1:1]};
        end
    end

    ////////////////////////////////////////////////////////////
    // Output beat
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            data_done_d <= 1'b0;
        end else begin
            data_done_d <= data_done;   // Last bit is in the shift register now
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_done_d) begin
            tdata_q <= rx_shift;
        end
    end

    // A new byte wins over an acceptance in the same cycle
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            tvalid_q <= 1'b0;
        end else if (data_done_d) begin
            tvalid_q <= 1'b1;
        end else if (m_axis.tready) begin
            tvalid_q <= 1'b0;
        end
    end

    assign m_axis.tvalid = tvalid_q;
    assign m_axis.tdata  = tdata_q;

endmodule
